/* include/mmap_define.svh */
// memory map region codes for the top address byte and the sd-card nibble

`ifndef MMAP_DEFINE_SVH
`define MMAP_DEFINE_SVH

// compared against addr[31:24]
`define FLASH_START   8'h00
`define APB_IP_START  8'h10
`define NATV_IP_START 8'h20
`define PSRAM0_START  8'h30
`define PSRAM1_START  8'h40
`define SRAM_START    8'h50

// sd card window is wider, compared against addr[31:28]
`define SPISD_START   4'h8

`endif

/* source/bus_pkg.sv */
// bus package with nmi request and response structs, region enum and address decode

`default_nettype none

`include "mmap_define.svh"

package bus_pkg;

  localparam int unsigned NMI_AW = 32;
  localparam int unsigned NMI_DW = 32;
  localparam int unsigned NMI_SW = NMI_DW / 8;

  // master to target, held stable from valid until ready
  typedef struct packed {
    logic              valid;
    logic [NMI_AW-1:0] addr;
    logic [NMI_DW-1:0] wdata;
    logic [NMI_SW-1:0] wstrb;
  } nmi_req_t;

  // target to master
  typedef struct packed {
    logic              ready;
    logic [NMI_DW-1:0] rdata;
  } nmi_rsp_t;

  typedef enum logic [1:0] {
    REGION_NATV,
    REGION_APB,
    REGION_SRAM,
    REGION_NONE
  } region_e;

  // psram and sd card live behind the native port
  function automatic region_e decode_region(input logic [NMI_AW-1:0] addr);
    logic [7:0] top;
    region_e    region;
    top = addr[31:24];
    if (top == `NATV_IP_START || top == `PSRAM0_START || top == `PSRAM1_START ||
        addr[31:28] == `SPISD_START) begin
      region = REGION_NATV;
    end else if (top == `FLASH_START || top == `APB_IP_START) begin
      region = REGION_APB;
    end else if (top == `SRAM_START) begin
      region = REGION_SRAM;
    end else begin
      region = REGION_NONE;
    end
    return region;
  endfunction

endpackage

`default_nettype wire

/* source/nmi_arbiter.sv */
// lock-and-id arbiter between core and dma masters on the nmi bus

`default_nettype none

module nmi_arbiter (
  input  logic              clk_i,
  input  logic              arst_n,
  input  bus_pkg::nmi_req_t core_req,
  output bus_pkg::nmi_rsp_t core_rsp,
  input  bus_pkg::nmi_req_t dma_req,
  output bus_pkg::nmi_rsp_t dma_rsp,
  output bus_pkg::nmi_req_t grant_req,
  input  bus_pkg::nmi_rsp_t grant_rsp
);

  logic lock_d;
  logic lock_q;
  // id 0 is the core, id 1 is the dma
  logic id_d;
  logic id_q;
  bus_pkg::nmi_req_t sel_req;

  // decide only while unlocked, dma has priority
  always_comb begin
    lock_d = lock_q;
    id_d   = id_q;
    if (!lock_q) begin
      if (dma_req.valid) begin
        lock_d = 1'b1;
        id_d   = 1'b1;
      end else if (core_req.valid) begin
        lock_d = 1'b1;
        id_d   = 1'b0;
      end
    end else if (grant_rsp.ready) begin
      // owner completes on this edge
      lock_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      lock_q <= 1'b0;
      id_q   <= 1'b0;
    end else begin
      lock_q <= lock_d;
      id_q   <= id_d;
    end
  end

  assign sel_req = id_q ? dma_req : core_req;

  // nothing is forwarded before the lock is taken
  always_comb begin
    grant_req       = sel_req;
    grant_req.valid = lock_q && sel_req.valid;
  end

  // response goes back to the owner only
  always_comb begin
    core_rsp = '0;
    dma_rsp  = '0;
    if (lock_q) begin
      if (id_q) begin
        dma_rsp = grant_rsp;
      end else begin
        core_rsp = grant_rsp;
      end
    end
  end

  // owner cannot be swapped in the middle of a transfer
  a_id_stable_while_locked : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    lock_q |=> $stable(id_q)
  );

  // a master that does not own the bus never completes
  a_core_ready_only_granted : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    core_rsp.ready |-> (lock_q && !id_q && core_req.valid)
  );

  a_dma_ready_only_granted : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    dma_rsp.ready |-> (lock_q && id_q && dma_req.valid)
  );

endmodule

`default_nettype wire

/* source/nmi_addr_decoder.sv */
// address decoder routing the granted request to native, apb or sram targets

`default_nettype none

module nmi_addr_decoder (
  input  logic              clk_i,
  input  logic              arst_n,
  input  bus_pkg::nmi_req_t grant_req,
  output bus_pkg::nmi_rsp_t grant_rsp,
  output bus_pkg::nmi_req_t natv_req,
  input  bus_pkg::nmi_rsp_t natv_rsp,
  output bus_pkg::nmi_req_t apb_req,
  input  bus_pkg::nmi_rsp_t apb_rsp,
  output bus_pkg::nmi_req_t sram_req,
  input  bus_pkg::nmi_rsp_t sram_rsp
);

  bus_pkg::region_e region;
  logic natv_hit;
  logic apb_hit;
  logic sram_hit;
  logic none_hit;
  // answers requests that match no region
  logic none_ready_q;

  assign region = bus_pkg::decode_region(grant_req.addr);

  assign natv_hit = grant_req.valid && (region == bus_pkg::REGION_NATV);
  assign apb_hit  = grant_req.valid && (region == bus_pkg::REGION_APB);
  assign sram_hit = grant_req.valid && (region == bus_pkg::REGION_SRAM);
  assign none_hit = grant_req.valid && (region == bus_pkg::REGION_NONE);

  // payload fans out to every target, valid only to the selected one
  always_comb begin
    natv_req       = grant_req;
    natv_req.valid = natv_hit;
  end

  always_comb begin
    apb_req       = grant_req;
    apb_req.valid = apb_hit;
  end

  always_comb begin
    sram_req       = grant_req;
    sram_req.valid = sram_hit;
  end

  // one pulse, one cycle after valid, same timing as the sram
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      none_ready_q <= 1'b0;
    end else begin
      none_ready_q <= none_hit && !none_ready_q;
    end
  end

  // ready counts only from the target whose valid is up
  always_comb begin
    grant_rsp = '0;
    if (natv_hit && natv_rsp.ready) begin
      grant_rsp = natv_rsp;
    end else if (apb_hit && apb_rsp.ready) begin
      grant_rsp = apb_rsp;
    end else if (sram_hit && sram_rsp.ready) begin
      grant_rsp = sram_rsp;
    end else if (none_hit && none_ready_q) begin
      // unmapped reads return zero
      grant_rsp.ready = 1'b1;
    end
  end

  a_one_target_valid : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    $onehot0({natv_req.valid, apb_req.valid, sram_req.valid})
  );

  // the unmapped answer must not overlap a real target
  a_none_ready_isolated : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    none_ready_q |-> !(natv_req.valid || apb_req.valid || sram_req.valid)
  );

endmodule

`default_nettype wire

/* source/sram_bank.sv */
// on-chip sram bank with byte write strobes and a single-pulse ready

`default_nettype none

module sram_bank #(
  parameter int unsigned SRAM_AW = 10
) (
  input  logic              clk_i,
  input  logic              arst_n,
  input  bus_pkg::nmi_req_t req,
  output bus_pkg::nmi_rsp_t rsp
);

  localparam int unsigned DEPTH = 2 ** SRAM_AW;

  logic [bus_pkg::NMI_DW-1:0] mem [DEPTH];
  logic [SRAM_AW-1:0]         word_addr;
  logic [bus_pkg::NMI_DW-1:0] rdata_q;
  logic                       ready_q;
  logic                       access;

  // upper bits inside the region alias
  assign word_addr = req.addr[SRAM_AW+1:2];

  // first cycle of a request, the edge that raises ready
  assign access = req.valid && !ready_q;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      for (int i = 0; i < bus_pkg::NMI_SW; i++) begin
        if (req.wstrb[i]) begin
          mem[word_addr][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
      rdata_q <= mem[word_addr];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

  // holds only if the master keeps valid up until it sees ready
  a_ready_needs_valid : assert property (
    @(posedge clk_i) disable iff (!arst_n)
    rsp.ready |-> req.valid
  );

endmodule

`default_nettype wire

/* source/bus.sv */
// bus top level with arbiter, address decoder and sram bank

`default_nettype none

module bus #(
  parameter int unsigned SRAM_AW = 10
) (
  input  logic              clk_i,
  input  logic              arst_n,
  input  bus_pkg::nmi_req_t core_req,
  output bus_pkg::nmi_rsp_t core_rsp,
  input  bus_pkg::nmi_req_t dma_req,
  output bus_pkg::nmi_rsp_t dma_rsp,
  output bus_pkg::nmi_req_t natv_req,
  input  bus_pkg::nmi_rsp_t natv_rsp,
  output bus_pkg::nmi_req_t apb_req,
  input  bus_pkg::nmi_rsp_t apb_rsp
);

  // granted master towards the decoder
  bus_pkg::nmi_req_t grant_req;
  bus_pkg::nmi_rsp_t grant_rsp;
  // internal sram port
  bus_pkg::nmi_req_t sram_req;
  bus_pkg::nmi_rsp_t sram_rsp;

  nmi_arbiter u_nmi_arbiter (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .core_req  (core_req),
    .core_rsp  (core_rsp),
    .dma_req   (dma_req),
    .dma_rsp   (dma_rsp),
    .grant_req (grant_req),
    .grant_rsp (grant_rsp)
  );

  nmi_addr_decoder u_nmi_addr_decoder (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .grant_req (grant_req),
    .grant_rsp (grant_rsp),
    .natv_req  (natv_req),
    .natv_rsp  (natv_rsp),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .sram_req  (sram_req),
    .sram_rsp  (sram_rsp)
  );

  sram_bank #(
    .SRAM_AW (SRAM_AW)
  ) u_sram_bank (
    .clk_i  (clk_i),
    .arst_n (arst_n),
    .req    (sram_req),
    .rsp    (sram_rsp)
  );

endmodule

`default_nettype wire

/* testbench/bus_checker.sv */
// bus monitor with reference read model, shadow sram and per-test reporting

`default_nettype none

module bus_checker #(
  parameter int unsigned SRAM_AW  = 10,
  parameter logic [31:0] NATV_KEY = 32'h0,
  parameter logic [31:0] APB_KEY  = 32'h0
) (
  input wire logic              clk_i,
  input wire logic              arst_n,
  input wire bus_pkg::nmi_req_t core_req,
  input wire bus_pkg::nmi_rsp_t core_rsp,
  input wire bus_pkg::nmi_req_t dma_req,
  input wire bus_pkg::nmi_rsp_t dma_rsp,
  input wire bus_pkg::nmi_req_t natv_req,
  input wire bus_pkg::nmi_rsp_t natv_rsp,
  input wire bus_pkg::nmi_req_t apb_req,
  input wire bus_pkg::nmi_rsp_t apb_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned DEPTH = 2 ** SRAM_AW;

  logic [31:0] shadow [DEPTH];
  // bytes of the shadow that hold a written value
  logic [3:0]  known [DEPTH];
  int          errors;
  int          checks;
  int          test_errors;
  logic        strict_latency;
  logic        seen_natv;
  logic        seen_apb;
  int          core_cnt;
  int          dma_cnt;
  bus_pkg::nmi_req_t prev_natv;
  bus_pkg::nmi_rsp_t prev_natv_rsp;
  bus_pkg::nmi_req_t prev_apb;
  bus_pkg::nmi_rsp_t prev_apb_rsp;

  initial begin
    errors         = 0;
    checks         = 0;
    test_errors    = 0;
    strict_latency = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      known[i] = 4'b0;
    end
  end

  task automatic fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    if (cond !== 1'b1) begin
      fail(msg);
    end
  endtask

  // expected read data from the memory map rules
  function automatic logic [31:0] ref_rdata(input logic [31:0] addr);
    bus_pkg::region_e rg;
    logic [31:0]      exp;
    rg = bus_pkg::decode_region(addr);
    case (rg)
      bus_pkg::REGION_NATV: exp = addr ^ NATV_KEY;
      bus_pkg::REGION_APB:  exp = addr ^ APB_KEY;
      bus_pkg::REGION_SRAM: exp = shadow[addr[SRAM_AW+1:2]];
      default:              exp = 32'h0;
    endcase
    return exp;
  endfunction

  // only written sram bytes are compared
  function automatic logic [31:0] ref_mask(input logic [31:0] addr);
    logic [31:0] mask;
    logic [3:0]  k;
    mask = 32'hffff_ffff;
    if (bus_pkg::decode_region(addr) == bus_pkg::REGION_SRAM) begin
      k = known[addr[SRAM_AW+1:2]];
      for (int i = 0; i < 4; i++) begin
        mask[i*8 +: 8] = {8{k[i]}};
      end
    end
    return mask;
  endfunction

  task automatic complete(input string who, input bus_pkg::nmi_req_t rq,
                          input bus_pkg::nmi_rsp_t rs, input int lat);
    bus_pkg::region_e rg;
    logic [31:0]      exp;
    logic [31:0]      mask;
    int unsigned      w;
    rg = bus_pkg::decode_region(rq.addr);
    w  = rq.addr[SRAM_AW+1:2];
    checks++;
    if (rq.wstrb == 4'b0) begin
      exp  = ref_rdata(rq.addr);
      mask = ref_mask(rq.addr);
      if ((rs.rdata & mask) !== (exp & mask)) begin
        fail($sformatf("%s read %h got %h expected %h", who, rq.addr, rs.rdata, exp));
      end
    end else if (rg == bus_pkg::REGION_SRAM) begin
      for (int i = 0; i < 4; i++) begin
        if (rq.wstrb[i]) begin
          shadow[w][i*8 +: 8] = rq.wdata[i*8 +: 8];
          known[w][i]         = 1'b1;
        end
      end
    end
    if (seen_natv !== (rg == bus_pkg::REGION_NATV) ||
        seen_apb !== (rg == bus_pkg::REGION_APB)) begin
      fail($sformatf("%s addr %h wrong target valid natv %b apb %b", who, rq.addr,
                     seen_natv, seen_apb));
    end
    // the target sees the master's address, data and strobes unchanged
    if (rg == bus_pkg::REGION_NATV && natv_req !== rq) begin
      fail($sformatf("%s native request %h differs from master request %h", who,
                     natv_req, rq));
    end
    if (rg == bus_pkg::REGION_APB && apb_req !== rq) begin
      fail($sformatf("%s apb request %h differs from master request %h", who,
                     apb_req, rq));
    end
    if (strict_latency && (rg == bus_pkg::REGION_SRAM || rg == bus_pkg::REGION_NONE) &&
        lat != 2) begin
      fail($sformatf("%s addr %h took %0d cycles", who, rq.addr, lat));
    end
  endtask

  // sampled away from the rising edge so every value is settled
  always @(negedge clk_i) begin
    if (!arst_n) begin
      seen_natv = 1'b0;
      seen_apb  = 1'b0;
      core_cnt  = 0;
      dma_cnt   = 0;
    end else begin
      if (prev_natv.valid && !prev_natv_rsp.ready && natv_req !== prev_natv) begin
        fail("native request changed before ready");
      end
      if (prev_apb.valid && !prev_apb_rsp.ready && apb_req !== prev_apb) begin
        fail("apb request changed before ready");
      end
      seen_natv = seen_natv | natv_req.valid;
      seen_apb  = seen_apb | apb_req.valid;
      if (core_req.valid && core_rsp.ready) begin
        complete("core", core_req, core_rsp, core_cnt);
        core_cnt  = 0;
        seen_natv = 1'b0;
        seen_apb  = 1'b0;
      end else if (core_req.valid) begin
        core_cnt++;
      end
      if (dma_req.valid && dma_rsp.ready) begin
        complete("dma", dma_req, dma_rsp, dma_cnt);
        dma_cnt   = 0;
        seen_natv = 1'b0;
        seen_apb  = 1'b0;
      end else if (dma_req.valid) begin
        dma_cnt++;
      end
    end
    prev_natv     = natv_req;
    prev_natv_rsp = natv_rsp;
    prev_apb      = apb_req;
    prev_apb_rsp  = apb_rsp;
  end

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic summary();
    $display("checks %0d, errors %0d", checks, errors);
  endtask

endmodule

`default_nettype wire

/* testbench/tb_bus.sv */
// testbench top with clock, reset, target models, masters and all test sequences

`default_nettype none

// external target with random latency, answers addr xor key
module target_model #(
  parameter logic [31:0] KEY = 32'h0
) (
  input  wire logic              clk_i,
  input  wire logic              arst_n,
  input  wire bus_pkg::nmi_req_t req,
  output bus_pkg::nmi_rsp_t      rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [1:0] lat_q;
  logic [1:0] cnt_q;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      lat_q <= 2'd0;
      cnt_q <= 2'd0;
    end else if (req.valid) begin
      if (rsp.ready) begin
        cnt_q <= 2'd0;
        lat_q <= 2'($urandom % 4);
      end else begin
        cnt_q <= cnt_q + 2'd1;
      end
    end
  end

  always_comb begin
    rsp.ready = req.valid && (cnt_q == lat_q);
    rsp.rdata = rsp.ready ? (req.addr ^ KEY) : 32'h0;
  end

endmodule

module tb_bus;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SRAM_AW  = 10;
  localparam logic [31:0] NATV_KEY = 32'h5a5a_c3c3;
  localparam logic [31:0] APB_KEY  = 32'h0f0f_9696;
  localparam int          TIMEOUT  = 50;

  logic              clk_i;
  logic              arst_n;
  bus_pkg::nmi_req_t core_req;
  bus_pkg::nmi_rsp_t core_rsp;
  bus_pkg::nmi_req_t dma_req;
  bus_pkg::nmi_rsp_t dma_rsp;
  bus_pkg::nmi_req_t natv_req;
  bus_pkg::nmi_rsp_t natv_rsp;
  bus_pkg::nmi_req_t apb_req;
  bus_pkg::nmi_rsp_t apb_rsp;

  bus #(.SRAM_AW(SRAM_AW)) UUT (
    .clk_i(clk_i), .arst_n(arst_n),
    .core_req(core_req), .core_rsp(core_rsp), .dma_req(dma_req), .dma_rsp(dma_rsp),
    .natv_req(natv_req), .natv_rsp(natv_rsp), .apb_req(apb_req), .apb_rsp(apb_rsp)
  );

  target_model #(.KEY(NATV_KEY)) u_natv (
    .clk_i(clk_i), .arst_n(arst_n), .req(natv_req), .rsp(natv_rsp)
  );

  target_model #(.KEY(APB_KEY)) u_apb (
    .clk_i(clk_i), .arst_n(arst_n), .req(apb_req), .rsp(apb_rsp)
  );

  bus_checker #(.SRAM_AW(SRAM_AW), .NATV_KEY(NATV_KEY), .APB_KEY(APB_KEY)) u_checker (
    .clk_i(clk_i), .arst_n(arst_n),
    .core_req(core_req), .core_rsp(core_rsp), .dma_req(dma_req), .dma_rsp(dma_rsp),
    .natv_req(natv_req), .natv_rsp(natv_rsp), .apb_req(apb_req), .apb_rsp(apb_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $finish;
  endtask

  // one transfer on either master, valid held until ready
  task automatic xfer(input bit is_dma, input logic [31:0] addr, input logic [31:0] wdata,
                      input logic [3:0] wstrb, output time t_done);
    bus_pkg::nmi_req_t rq;
    int                n;
    rq.valid = 1'b1;
    rq.addr  = addr;
    rq.wdata = wdata;
    rq.wstrb = wstrb;
    @(posedge clk_i);
    #1;
    if (is_dma) dma_req = rq;
    else core_req = rq;
    n = 0;
    @(negedge clk_i);
    while (!(is_dma ? dma_rsp.ready : core_rsp.ready) && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!(is_dma ? dma_rsp.ready : core_rsp.ready)) begin
      abort_run($sformatf("timeout waiting for ready on %s at %h",
                          is_dma ? "dma" : "core", addr));
    end else begin
      @(posedge clk_i);
      t_done = $time;
      #1;
      if (is_dma) dma_req = '0;
      else core_req = '0;
    end
  endtask

  function automatic logic [31:0] rand_addr();
    logic [31:0] low;
    low = {8'h0, 14'($urandom), 8'($urandom % 16), 2'b00};
    case ($urandom % 9)
      0: return {8'h00, low[23:0]};
      1: return {8'h10, low[23:0]};
      2: return {8'h20, low[23:0]};
      3: return {8'h30, low[23:0]};
      4: return {8'h40, low[23:0]};
      5: return {4'h8, 4'($urandom), low[23:0]};
      6: return {8'h60, low[23:0]};
      default: return {8'h50, 18'h0, 4'($urandom % 16), 2'b00};
    endcase
  endfunction

  task automatic random_traffic(input bit is_dma, input int count);
    logic [31:0] addr;
    logic [3:0]  strb;
    time         t;
    for (int i = 0; i < count; i++) begin
      addr = rand_addr();
      strb = ($urandom % 2) ? 4'($urandom) : 4'b0;
      xfer(is_dma, addr, $urandom, strb, t);
    end
  endtask

  initial begin
    logic [7:0]  codes [7];
    logic [31:0] sram_base;
    logic [31:0] alias_bit;
    time         t_core;
    time         t_dma;
    void'($urandom(32'h6ec8_e331));
    codes    = '{8'h00, 8'h10, 8'h20, 8'h30, 8'h40, 8'h85, 8'h8f};
    core_req = '0;
    dma_req  = '0;
    arst_n   = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n = 1'b1;

    // 1: idle outputs after reset
    repeat (3) @(negedge clk_i);
    u_checker.check_true(!core_rsp.ready && !dma_rsp.ready, "master ready high when idle");
    u_checker.check_true(!natv_req.valid && !apb_req.valid, "target valid high when idle");
    u_checker.end_test("reset");

    // 2: reads on every mapped external code
    foreach (codes[i]) begin
      xfer(1'b0, {codes[i], 24'h00_1234} + 32'(i * 4), 32'h0, 4'b0, t_core);
      xfer(1'b1, {codes[i], 24'h03_ff00}, 32'h0, 4'b0, t_dma);
    end
    u_checker.end_test("region_reads");

    // 3: sram writes with strobes, aliased reads
    u_checker.strict_latency = 1'b1;
    sram_base = 32'h5000_0000;
    alias_bit = 32'h1 << (UUT.SRAM_AW + 2);
    for (int i = 0; i < 8; i++) begin
      xfer(1'b0, sram_base + 32'(i * 4), 32'hc0de_0000 + 32'(i), 4'hf, t_core);
    end
    xfer(1'b0, sram_base + 32'h4, 32'h1122_3344, 4'b0101, t_core);
    xfer(1'b1, sram_base + 32'h8, 32'haabb_ccdd, 4'b1000, t_dma);
    xfer(1'b1, sram_base + 32'hc, 32'h5566_7788, 4'b0110, t_dma);
    for (int i = 0; i < 8; i++) begin
      xfer(i[0], sram_base + 32'(i * 4), 32'h0, 4'b0, t_core);
      xfer(1'b0, sram_base + alias_bit + 32'(i * 4), 32'h0, 4'b0, t_core);
    end
    u_checker.end_test("sram_strobes");

    // 4: dma priority and lock held by the core
    u_checker.strict_latency = 1'b0;
    fork
      xfer(1'b0, sram_base + 32'h10, 32'h0, 4'b0, t_core);
      xfer(1'b1, sram_base + 32'h14, 32'h0, 4'b0, t_dma);
    join
    u_checker.check_true(t_dma < t_core, "dma did not win the same-cycle request");
    // sram keeps the core locked for a full cycle after the dma valid rises
    fork
      xfer(1'b0, sram_base + 32'h18, 32'h0, 4'b0, t_core);
      begin
        @(posedge clk_i);
        xfer(1'b1, 32'h1000_0080, 32'h0, 4'b0, t_dma);
      end
    join
    u_checker.check_true(t_core < t_dma, "locked core transfer was interrupted");
    u_checker.end_test("arbitration");

    // 5: unmapped addresses
    u_checker.strict_latency = 1'b1;
    xfer(1'b0, 32'h6000_0010, 32'h0, 4'b0, t_core);
    xfer(1'b1, 32'hf000_0000, 32'h0, 4'b0, t_dma);
    xfer(1'b0, 32'h7123_4560, 32'hdead_beef, 4'hf, t_core);
    u_checker.end_test("unmapped");

    // 6: mixed random traffic from both masters
    u_checker.strict_latency = 1'b0;
    fork
      random_traffic(1'b0, 40);
      random_traffic(1'b1, 40);
    join
    u_checker.end_test("random_traffic");

    repeat (2) @(posedge clk_i);
    u_checker.summary();
    if (u_checker.errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/bus_pkg.sv
source/nmi_arbiter.sv
source/nmi_addr_decoder.sv
source/sram_bank.sv
source/bus.sv
testbench/bus_checker.sv
testbench/tb_bus.sv

/* Bender.yml */
package:
  name: nmi_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/bus_pkg.sv
      - source/nmi_arbiter.sv
      - source/nmi_addr_decoder.sv
      - source/sram_bank.sv
      - source/bus.sv
  - target: test
    files:
      - testbench/bus_checker.sv
      - testbench/tb_bus.sv
